//--- common/chip_pkg.sv
/*
  Shared sizes, address map and bus types for the always-on CTN harness.
  All sizes are fixed here; modules carry no parameters of their own.
*/
package chip_pkg;

  //////////////////////
  // Bus and bank sizes
  //////////////////////
  localparam int unsigned ADDR_W    = 32;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned STRB_W    = 4;
  localparam int unsigned NUM_PINS  = 32;
  localparam int unsigned NUM_PADS  = 19;
  localparam int unsigned POR_CNT_W = 4;

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [STRB_W-1:0]    strb_t;
  typedef logic [NUM_PINS-1:0]  pin_vec_t;
  typedef logic [NUM_PADS-1:0]  pad_vec_t;
  typedef logic [7:0]           word_idx_t;
  typedef logic [POR_CNT_W-1:0] por_cnt_t;

  //////////////////////
  // Address map
  //////////////////////
  localparam addr_t       CTN_BASE  = 32'h4000_0000;
  localparam int unsigned CTN_SIZE  = 1024;
  localparam int unsigned CTN_DEPTH = 256;
  localparam addr_t       PAD_BASE  = 32'h5000_0000;
  localparam int unsigned PAD_SIZE  = 64;

  // Pad register offsets
  localparam addr_t PAD_OUT_OFS      = 32'h0;
  localparam addr_t PAD_OE_OFS       = 32'h4;
  localparam addr_t PAD_PULL_EN_OFS  = 32'h8;
  localparam addr_t PAD_PULL_SEL_OFS = 32'hC;
  localparam addr_t PAD_IN_OFS       = 32'h10;

  //////////////////////
  // Pad to pin map
  //////////////////////
  // Generic GPIOs sit on pads and pins 0 up to NUM_GPIO-1
  localparam int unsigned NUM_GPIO        = 14;
  localparam int unsigned NUM_SW_STRAPS   = 3;
  localparam int unsigned PAD_SW_STRAP_LO = 14;
  localparam int unsigned PAD_TAP_STRAP1  = 17;
  localparam int unsigned PAD_TAP_STRAP0  = 18;
  localparam int unsigned PIN_SW_STRAP_LO = 22;
  localparam int unsigned PIN_TAP_STRAP1  = 27;
  localparam int unsigned PIN_TAP_STRAP0  = 30;

  typedef struct packed {
    logic  psel;
    logic  penable;
    logic  pwrite;
    addr_t paddr;
    data_t pwdata;
    strb_t pstrb;
  } apb_req_t;

  typedef struct packed {
    logic  pready;
    data_t prdata;
    logic  pslverr;
  } apb_rsp_t;

  typedef struct packed {
    pad_vec_t out;
    pad_vec_t oe;
    pad_vec_t pull_en;
    pad_vec_t pull_sel;
  } pad_ctrl_t;

  typedef struct packed {
    pin_vec_t d2p;
    pin_vec_t en_d2p;
    pin_vec_t pull_en;
    pin_vec_t pull_select;
  } gpio_pins_t;

  typedef enum logic [1:0] {
    SRAM_IDLE,
    SRAM_WAIT,
    SRAM_DONE
  } sram_state_e;

endpackage

//--- design/por_sequencer.sv
/*
  Counter restarts on rst_i and saturates; the core stays in reset until
  saturation, 15 cycles after rst_i falls.
*/
`timescale 1ns/1ps

module por_sequencer (
  input  logic clk_aon,
  input  logic rst_i,
  output logic vcc_supp_o,
  output logic por_done_o,
  output logic core_rst_o
);

  chip_pkg::por_cnt_t cnt_q;

  // Count up and hold at the top
  always_ff @(posedge clk_aon) begin
    if (rst_i) begin
      cnt_q <= '0;
    end else if (cnt_q != '1) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // Supply glitches low, high, low, then settles high
  always_comb begin
    case (cnt_q[chip_pkg::POR_CNT_W-1 -: 2])
      2'b00:   vcc_supp_o = 1'b0;
      2'b01:   vcc_supp_o = 1'b1;
      2'b10:   vcc_supp_o = 1'b0;
      default: vcc_supp_o = 1'b1;
    endcase
  end

  assign por_done_o = (cnt_q == '1);
  assign core_rst_o = rst_i | ~por_done_o;

endmodule

//--- ctn/ctn_decoder.sv
/*
  Window is decoded once in the setup phase and held for the transfer.
  Addresses outside both windows get an error in the first access cycle.
*/
`timescale 1ns/1ps

module ctn_decoder (
  input  logic               clk_aon,
  input  logic               rst_i,
  input  chip_pkg::apb_req_t host_req_i,
  output chip_pkg::apb_rsp_t host_rsp_o,
  output chip_pkg::apb_req_t sram_req_o,
  input  chip_pkg::apb_rsp_t sram_rsp_i,
  output chip_pkg::apb_req_t pad_req_o,
  input  chip_pkg::apb_rsp_t pad_rsp_i
);

  logic setup_phase;
  logic sram_hit, pad_hit;
  logic sram_sel, pad_sel;
  logic sram_sel_q, pad_sel_q, err_sel_q;

  assign setup_phase = host_req_i.psel & ~host_req_i.penable;

  // Window match on the masked address
  assign sram_hit = (host_req_i.paddr & ~chip_pkg::addr_t'(chip_pkg::CTN_SIZE - 1)) ==
                    chip_pkg::CTN_BASE;
  assign pad_hit  = (host_req_i.paddr & ~chip_pkg::addr_t'(chip_pkg::PAD_SIZE - 1)) ==
                    chip_pkg::PAD_BASE;

  always_ff @(posedge clk_aon) begin
    if (rst_i) begin
      sram_sel_q <= 1'b0;
      pad_sel_q  <= 1'b0;
      err_sel_q  <= 1'b0;
    end else if (setup_phase) begin
      sram_sel_q <= sram_hit;
      pad_sel_q  <= pad_hit;
      err_sel_q  <= ~sram_hit & ~pad_hit;
    end
  end

  // Live decode during setup, held selection afterwards
  assign sram_sel = setup_phase ? sram_hit : sram_sel_q;
  assign pad_sel  = setup_phase ? pad_hit  : pad_sel_q;

  always_comb begin
    sram_req_o      = host_req_i;
    sram_req_o.psel = host_req_i.psel & sram_sel;
    pad_req_o       = host_req_i;
    pad_req_o.psel  = host_req_i.psel & pad_sel;
  end

  //////////////////////
  // Response mux
  //////////////////////
  always_comb begin
    host_rsp_o = '0;
    if (sram_sel_q) begin
      host_rsp_o = sram_rsp_i;
    end else if (pad_sel_q) begin
      host_rsp_o = pad_rsp_i;
    end else if (err_sel_q) begin
      host_rsp_o.pready  = host_req_i.psel & host_req_i.penable;
      host_rsp_o.pslverr = host_rsp_o.pready;
    end
  end

endmodule

//--- ctn/ctn_sram.sv
/*
  One fixed wait state: pready comes in the second access cycle.
  Word addressed by paddr bits above the byte lane; never signals an error.
*/
`timescale 1ns/1ps

module ctn_sram (
  input  logic               clk_aon,
  input  logic               rst_i,
  input  chip_pkg::apb_req_t req_i,
  output chip_pkg::apb_rsp_t rsp_o
);

  chip_pkg::data_t       mem [chip_pkg::CTN_DEPTH];
  chip_pkg::data_t       rdata_q;
  chip_pkg::word_idx_t   word_idx;
  chip_pkg::sram_state_e state_q, state_d;

  assign word_idx = chip_pkg::word_idx_t'(req_i.paddr >> 2);

  //////////////////////
  // Wait-state FSM
  //////////////////////
  // IDLE sees the setup, WAIT is the first access cycle and does the RAM
  // access, DONE returns the response
  always_comb begin
    state_d = state_q;
    case (state_q)
      chip_pkg::SRAM_IDLE: begin
        if (req_i.psel) begin
          state_d = chip_pkg::SRAM_WAIT;
        end
      end
      chip_pkg::SRAM_WAIT: begin
        if (req_i.psel & req_i.penable) begin
          state_d = chip_pkg::SRAM_DONE;
        end
      end
      default: state_d = chip_pkg::SRAM_IDLE;
    endcase
  end

  always_ff @(posedge clk_aon) begin
    if (rst_i) begin
      state_q <= chip_pkg::SRAM_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // RAM array and registered read port
  always_ff @(posedge clk_aon) begin
    if (state_q == chip_pkg::SRAM_WAIT && req_i.psel && req_i.penable) begin
      if (req_i.pwrite) begin
        for (int b = 0; b < chip_pkg::STRB_W; b++) begin
          if (req_i.pstrb[b]) begin
            mem[word_idx][8*b +: 8] <= req_i.pwdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  always_comb begin
    rsp_o         = '0;
    rsp_o.pready  = (state_q == chip_pkg::SRAM_DONE) & req_i.psel & req_i.penable;
    rsp_o.prdata  = rdata_q;
    rsp_o.pslverr = 1'b0;
  end

endmodule

//--- padring/pad_regs.sv
/*
  Zero-wait register file; pstrb is ignored, writes take the low 19 bits.
  PAD_IN_OFS is read only; writes to it and unlisted offsets return pslverr.
*/
`timescale 1ns/1ps

module pad_regs (
  input  logic                clk_aon,
  input  logic                rst_i,
  input  chip_pkg::apb_req_t  req_i,
  output chip_pkg::apb_rsp_t  rsp_o,
  input  chip_pkg::pad_vec_t  pad_in_i,
  output chip_pkg::pad_ctrl_t pad_ctrl_o
);

  chip_pkg::addr_t     ofs;
  chip_pkg::pad_vec_t  rd_vec;
  chip_pkg::pad_vec_t  wr_vec;
  chip_pkg::pad_ctrl_t ctrl_q;
  logic                access;
  logic                ofs_ok;
  logic                bad;

  assign ofs    = req_i.paddr & chip_pkg::addr_t'(chip_pkg::PAD_SIZE - 1);
  assign access = req_i.psel & req_i.penable;
  assign wr_vec = chip_pkg::pad_vec_t'(req_i.pwdata);

  // Offset decode and read mux
  always_comb begin
    ofs_ok = 1'b1;
    rd_vec = '0;
    case (ofs)
      chip_pkg::PAD_OUT_OFS:      rd_vec = ctrl_q.out;
      chip_pkg::PAD_OE_OFS:       rd_vec = ctrl_q.oe;
      chip_pkg::PAD_PULL_EN_OFS:  rd_vec = ctrl_q.pull_en;
      chip_pkg::PAD_PULL_SEL_OFS: rd_vec = ctrl_q.pull_sel;
      chip_pkg::PAD_IN_OFS:       rd_vec = pad_in_i;
      default:                    ofs_ok = 1'b0;
    endcase
  end

  assign bad = ~ofs_ok | (req_i.pwrite & (ofs == chip_pkg::PAD_IN_OFS));

  always_ff @(posedge clk_aon) begin
    if (rst_i) begin
      ctrl_q <= '0;
    end else if (access && req_i.pwrite && !bad) begin
      case (ofs)
        chip_pkg::PAD_OUT_OFS:      ctrl_q.out      <= wr_vec;
        chip_pkg::PAD_OE_OFS:       ctrl_q.oe       <= wr_vec;
        chip_pkg::PAD_PULL_EN_OFS:  ctrl_q.pull_en  <= wr_vec;
        chip_pkg::PAD_PULL_SEL_OFS: ctrl_q.pull_sel <= wr_vec;
        default: ;
      endcase
    end
  end

  always_comb begin
    rsp_o         = '0;
    rsp_o.pready  = access;
    rsp_o.prdata  = chip_pkg::data_t'(rd_vec);
    rsp_o.pslverr = access & bad;
  end

  assign pad_ctrl_o = ctrl_q;

endmodule

//--- padring/pad_map.sv
/*
  Fixed map of 19 logical pads onto the 32-pin bank; unmapped pins read as
  don't care and are driven low. Inputs pass a two-flop synchronizer.
*/
`timescale 1ns/1ps

module pad_map (
  input  logic                 clk_aon,
  input  logic                 rst_i,
  input  chip_pkg::pad_ctrl_t  pad_ctrl_i,
  input  chip_pkg::pin_vec_t   gpio_p2d_i,
  output chip_pkg::gpio_pins_t gpio_o,
  output chip_pkg::pad_vec_t   pad_in_o
);

  chip_pkg::pad_vec_t pad_raw;
  chip_pkg::pad_vec_t sync_q1, sync_q2;

  // Pad vector onto pin positions, everything else zero
  function automatic chip_pkg::pin_vec_t scatter(chip_pkg::pad_vec_t pads);
    chip_pkg::pin_vec_t pins;
    pins = '0;
    pins[chip_pkg::NUM_GPIO-1:0] = pads[chip_pkg::NUM_GPIO-1:0];
    pins[chip_pkg::PIN_SW_STRAP_LO +: chip_pkg::NUM_SW_STRAPS] =
      pads[chip_pkg::PAD_SW_STRAP_LO +: chip_pkg::NUM_SW_STRAPS];
    pins[chip_pkg::PIN_TAP_STRAP1] = pads[chip_pkg::PAD_TAP_STRAP1];
    pins[chip_pkg::PIN_TAP_STRAP0] = pads[chip_pkg::PAD_TAP_STRAP0];
    return pins;
  endfunction

  // Gather mapped pins back into pad order
  always_comb begin
    pad_raw = '0;
    pad_raw[chip_pkg::NUM_GPIO-1:0] = gpio_p2d_i[chip_pkg::NUM_GPIO-1:0];
    pad_raw[chip_pkg::PAD_SW_STRAP_LO +: chip_pkg::NUM_SW_STRAPS] =
      gpio_p2d_i[chip_pkg::PIN_SW_STRAP_LO +: chip_pkg::NUM_SW_STRAPS];
    pad_raw[chip_pkg::PAD_TAP_STRAP1] = gpio_p2d_i[chip_pkg::PIN_TAP_STRAP1];
    pad_raw[chip_pkg::PAD_TAP_STRAP0] = gpio_p2d_i[chip_pkg::PIN_TAP_STRAP0];
  end

  always_ff @(posedge clk_aon) begin
    if (rst_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= pad_raw;
      sync_q2 <= sync_q1;
    end
  end

  assign pad_in_o = sync_q2;

  assign gpio_o.d2p         = scatter(pad_ctrl_i.out);
  assign gpio_o.en_d2p      = scatter(pad_ctrl_i.oe);
  assign gpio_o.pull_en     = scatter(pad_ctrl_i.pull_en);
  assign gpio_o.pull_select = scatter(pad_ctrl_i.pull_sel);

endmodule

//--- design/chip_ctn_top.sv
/*
  Always-on harness top. The APB host must stay idle until por_done_o;
  the whole core is held in reset before that.
*/
`timescale 1ns/1ps

module chip_ctn_top (
  input  logic                 clk_aon,
  input  logic                 rst_i,
  input  chip_pkg::apb_req_t   apb_req_i,
  output chip_pkg::apb_rsp_t   apb_rsp_o,
  input  chip_pkg::pin_vec_t   gpio_p2d_i,
  output chip_pkg::gpio_pins_t gpio_o,
  output logic                 vcc_supp_o,
  output logic                 por_done_o
);

  logic                core_rst;
  chip_pkg::apb_req_t  sram_req, pad_req;
  chip_pkg::apb_rsp_t  sram_rsp, pad_rsp;
  chip_pkg::pad_ctrl_t pad_ctrl;
  chip_pkg::pad_vec_t  pad_in;

  //////////////////////
  // Power-on
  //////////////////////
  por_sequencer por_sequencer_inst (
    .clk_aon    (clk_aon),
    .rst_i      (rst_i),
    .vcc_supp_o (vcc_supp_o),
    .por_done_o (por_done_o),
    .core_rst_o (core_rst)
  );

  //////////////////////
  // CTN window
  //////////////////////
  ctn_decoder ctn_decoder_inst (
    .clk_aon    (clk_aon),
    .rst_i      (core_rst),
    .host_req_i (apb_req_i),
    .host_rsp_o (apb_rsp_o),
    .sram_req_o (sram_req),
    .sram_rsp_i (sram_rsp),
    .pad_req_o  (pad_req),
    .pad_rsp_i  (pad_rsp)
  );

  ctn_sram ctn_sram_inst (
    .clk_aon (clk_aon),
    .rst_i   (core_rst),
    .req_i   (sram_req),
    .rsp_o   (sram_rsp)
  );

  //////////////////////
  // Pad ring
  //////////////////////
  pad_regs pad_regs_inst (
    .clk_aon    (clk_aon),
    .rst_i      (core_rst),
    .req_i      (pad_req),
    .rsp_o      (pad_rsp),
    .pad_in_i   (pad_in),
    .pad_ctrl_o (pad_ctrl)
  );

  pad_map pad_map_inst (
    .clk_aon    (clk_aon),
    .rst_i      (core_rst),
    .pad_ctrl_i (pad_ctrl),
    .gpio_p2d_i (gpio_p2d_i),
    .gpio_o     (gpio_o),
    .pad_in_o   (pad_in)
  );

endmodule

//--- sim/chip_ctn_assertions.sv
/*
  Bound to ctn_decoder, so rst_i here is the internal core reset.
  Checks the host side of the APB port only.
*/
`timescale 1ns/1ps

module chip_ctn_assertions (
  input logic               clk_aon,
  input logic               rst_i,
  input chip_pkg::apb_req_t host_req_i,
  input chip_pkg::apb_rsp_t host_rsp_i
);

  // Failed assertions so far, read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // Setup leads into access, and the request holds until pready
  property req_stable_p;
    @(posedge clk_aon) disable iff (rst_i)
      (host_req_i.psel && !host_rsp_i.pready) |=>
        (host_req_i.psel && host_req_i.penable &&
         $stable(host_req_i.paddr) && $stable(host_req_i.pwrite) &&
         $stable(host_req_i.pwdata) && $stable(host_req_i.pstrb));
  endproperty

  property ready_in_access_p;
    @(posedge clk_aon) disable iff (rst_i)
      host_rsp_i.pready |-> (host_req_i.psel && host_req_i.penable);
  endproperty

  // No response at all while the core is held in reset
  property quiet_in_reset_p;
    @(posedge clk_aon) rst_i |-> !host_rsp_i.pready;
  endproperty

  req_stable_a: assert property (req_stable_p)
    else begin
      $error("APB request changed or dropped before pready");
      fail_count++;
    end
  ready_in_access_a: assert property (ready_in_access_p)
    else begin
      $error("pready high outside an APB access phase");
      fail_count++;
    end
  quiet_in_reset_a: assert property (quiet_in_reset_p)
    else begin
      $error("pready high during core reset");
      fail_count++;
    end

endmodule

bind ctn_decoder chip_ctn_assertions chip_ctn_assertions_inst (
  .clk_aon    (clk_aon),
  .rst_i      (rst_i),
  .host_req_i (host_req_i),
  .host_rsp_i (host_rsp_o)
);

//--- sim/chip_ctn_tb.sv
/*
  Drives the harness top through power-on, RAM, decode error and pad tests.
  Inputs change 1 ns after the rising edge; outputs are sampled at the falling edge.
*/
`timescale 1ns/1ps

module chip_ctn_tb;

  localparam logic [31:0] SEED        = 32'h1f30_768e;
  localparam int          DRIVE_DLY   = 1;
  localparam int          APB_TIMEOUT = 16;
  localparam int          POR_TIMEOUT = 40;
  localparam int          RAM_WORDS   = 16;
  localparam int          RAM_OPS     = 40;
  localparam int          ITERS       = 20;

  logic                 clk_aon;
  logic                 rst_i;
  chip_pkg::apb_req_t   apb_req;
  chip_pkg::apb_rsp_t   apb_rsp;
  chip_pkg::pin_vec_t   gpio_p2d;
  chip_pkg::gpio_pins_t gpio_pins;
  logic                 vcc_supp;
  logic                 por_done;
  logic [31:0]          rng_state;
  int                   error_count;
  chip_pkg::data_t      ram_model [chip_pkg::CTN_DEPTH];
  // out, oe, pull_en, pull_sel in register order
  chip_pkg::pad_vec_t   pad_model [4];

  chip_ctn_top chip_ctn_top_inst (
    .clk_aon    (clk_aon),
    .rst_i      (rst_i),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp),
    .gpio_p2d_i (gpio_p2d),
    .gpio_o     (gpio_pins),
    .vcc_supp_o (vcc_supp),
    .por_done_o (por_done)
  );

  initial begin
    clk_aon = 1'b0;
    forever #10 clk_aon = ~clk_aon;
  end

  //////////////////////
  // Helpers
  //////////////////////
  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int pin_of_pad(int pad);
    if (pad < chip_pkg::NUM_GPIO) return pad;
    if (pad < chip_pkg::PAD_TAP_STRAP1) begin
      return chip_pkg::PIN_SW_STRAP_LO + (pad - chip_pkg::PAD_SW_STRAP_LO);
    end
    if (pad == chip_pkg::PAD_TAP_STRAP1) return chip_pkg::PIN_TAP_STRAP1;
    return chip_pkg::PIN_TAP_STRAP0;
  endfunction

  function automatic chip_pkg::pin_vec_t spread_pads(chip_pkg::pad_vec_t pads);
    chip_pkg::pin_vec_t pins;
    pins = '0;
    for (int p = 0; p < chip_pkg::NUM_PADS; p++) pins[pin_of_pad(p)] = pads[p];
    return pins;
  endfunction

  function automatic chip_pkg::pad_vec_t gather_pins(chip_pkg::pin_vec_t pins);
    chip_pkg::pad_vec_t pads;
    for (int p = 0; p < chip_pkg::NUM_PADS; p++) pads[p] = pins[pin_of_pad(p)];
    return pads;
  endfunction

  function automatic chip_pkg::gpio_pins_t expected_gpio();
    chip_pkg::gpio_pins_t g;
    g.d2p         = spread_pads(pad_model[0]);
    g.en_d2p      = spread_pads(pad_model[1]);
    g.pull_en     = spread_pads(pad_model[2]);
    g.pull_select = spread_pads(pad_model[3]);
    return g;
  endfunction

  // Low for 0-3, high 4-7, low 8-11, high from 12
  function automatic logic expected_supply(int count);
    return (count >= 4 && count < 8) || count >= 12;
  endfunction

  function automatic logic in_windows(chip_pkg::addr_t a);
    return (a >= chip_pkg::CTN_BASE && a < chip_pkg::CTN_BASE + chip_pkg::CTN_SIZE) ||
           (a >= chip_pkg::PAD_BASE && a < chip_pkg::PAD_BASE + chip_pkg::PAD_SIZE);
  endfunction

  task automatic report_failure();
    error_count++;
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic compare_data(input string name, input chip_pkg::data_t expected,
                              input chip_pkg::data_t actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      report_failure();
    end
  endtask

  task automatic compare_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
      report_failure();
    end
  endtask

  task automatic compare_pins(input string name, input chip_pkg::gpio_pins_t expected,
                              input chip_pkg::gpio_pins_t actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      report_failure();
    end
  endtask

  task automatic compare_cycles(input string name, input int expected, input int actual);
    if (actual != expected) begin
      $display("Fail %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
      report_failure();
    end
  endtask

  // One APB transfer; cycles counts access cycles up to and including pready
  task automatic apb_transfer(input chip_pkg::addr_t addr, input logic write,
                              input chip_pkg::data_t wdata, input chip_pkg::strb_t strb,
                              output chip_pkg::data_t rdata, output logic slverr,
                              output int cycles);
    logic done;
    done   = 1'b0;
    cycles = 0;
    @(posedge clk_aon);
    #DRIVE_DLY;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    apb_req.pstrb   = strb;
    @(posedge clk_aon);
    #DRIVE_DLY;
    apb_req.penable = 1'b1;
    while (!done) begin
      @(negedge clk_aon);
      cycles++;
      if (apb_rsp.pready) begin
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        done   = 1'b1;
      end else if (cycles >= APB_TIMEOUT) begin
        $display("Timeout: no pready after %0d access cycles at address %h", cycles, addr);
        report_failure();
      end
      @(posedge clk_aon);
    end
    #DRIVE_DLY;
    apb_req = '0;
  endtask

  //////////////////////
  // Tests
  //////////////////////
  task automatic test_power_on();
    int   cyc;
    logic done;
    cyc  = 0;
    done = 1'b0;
    // Pad write held in the access phase while the core is still in reset
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b1;
    apb_req.pwrite  = 1'b1;
    apb_req.paddr   = chip_pkg::PAD_BASE + chip_pkg::PAD_OUT_OFS;
    apb_req.pwdata  = '1;
    apb_req.pstrb   = '1;
    while (!done) begin
      @(negedge clk_aon);
      compare_flag("power_on_supply", expected_supply(cyc), vcc_supp);
      if (por_done) begin
        done = 1'b1;
      end else begin
        compare_pins("power_on_gpio", '0, gpio_pins);
        compare_flag("power_on_pready", 1'b0, apb_rsp.pready);
        if (cyc >= POR_TIMEOUT) begin
          $display("Timeout: power-on done never rose");
          report_failure();
        end
        @(posedge clk_aon);
        cyc++;
        // Bus released one cycle before the core leaves reset
        if (cyc == 14) begin
          #DRIVE_DLY;
          apb_req = '0;
        end
      end
    end
    compare_cycles("power_on_delay", 15, cyc);
    // Saturated: supply and done stay high
    repeat (4) begin
      @(negedge clk_aon);
      compare_flag("power_on_supply", 1'b1, vcc_supp);
      compare_flag("power_on_done", 1'b1, por_done);
    end
  endtask

  task automatic test_ram();
    chip_pkg::word_idx_t idx [RAM_WORDS];
    chip_pkg::word_idx_t w;
    chip_pkg::data_t     wdata;
    chip_pkg::data_t     rdata;
    chip_pkg::strb_t     strb;
    logic                slverr;
    int                  cycles;
    // Full-word fill first so every read word is defined
    for (int i = 0; i < RAM_WORDS + RAM_OPS; i++) begin
      if (i < RAM_WORDS) begin
        idx[i] = chip_pkg::word_idx_t'(next_random());
        w      = idx[i];
        strb   = '1;
      end else begin
        w    = idx[next_random() % RAM_WORDS];
        strb = chip_pkg::strb_t'(next_random());
      end
      wdata = next_random();
      apb_transfer(chip_pkg::CTN_BASE + (chip_pkg::addr_t'(w) << 2), 1'b1, wdata, strb,
                   rdata, slverr, cycles);
      for (int b = 0; b < chip_pkg::STRB_W; b++) begin
        if (strb[b]) ram_model[w][8*b +: 8] = wdata[8*b +: 8];
      end
      compare_flag("ram_write_err", 1'b0, slverr);
      compare_cycles("ram_write_wait", 2, cycles);
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      apb_transfer(chip_pkg::CTN_BASE + (chip_pkg::addr_t'(idx[i]) << 2), 1'b0, '0, '0,
                   rdata, slverr, cycles);
      compare_data("ram_read", ram_model[idx[i]], rdata);
      compare_flag("ram_read_err", 1'b0, slverr);
      compare_cycles("ram_read_wait", 2, cycles);
    end
  endtask

  task automatic test_decode_error();
    chip_pkg::addr_t addr;
    chip_pkg::data_t rdata;
    logic [31:0]     r;
    logic            slverr;
    int              cycles;
    for (int i = 0; i < ITERS; i++) begin
      r    = next_random();
      addr = r;
      // Half of them just past the end of the RAM window
      if (i % 2 == 0) addr = chip_pkg::CTN_BASE + chip_pkg::CTN_SIZE + (r & 32'hfffc);
      if (in_windows(addr)) addr[31] = ~addr[31];
      apb_transfer(addr, r[7], next_random(), '1, rdata, slverr, cycles);
      compare_flag("decode_error_err", 1'b1, slverr);
      compare_data("decode_error_data", '0, rdata);
      compare_cycles("decode_error_wait", 1, cycles);
    end
  endtask

  task automatic test_pad_outputs();
    chip_pkg::data_t wdata;
    chip_pkg::data_t rdata;
    logic            slverr;
    int              sel;
    int              cycles;
    for (int i = 0; i < ITERS; i++) begin
      sel   = next_random() % 4;
      wdata = next_random();
      apb_transfer(chip_pkg::PAD_BASE + chip_pkg::addr_t'(sel * 4), 1'b1, wdata, '1,
                   rdata, slverr, cycles);
      pad_model[sel] = chip_pkg::pad_vec_t'(wdata);
      compare_flag("pad_write_err", 1'b0, slverr);
      compare_cycles("pad_write_wait", 1, cycles);
      @(negedge clk_aon);
      compare_pins("pad_outputs", expected_gpio(), gpio_pins);
    end
    for (int s = 0; s < 4; s++) begin
      apb_transfer(chip_pkg::PAD_BASE + chip_pkg::addr_t'(s * 4), 1'b0, '0, '0,
                   rdata, slverr, cycles);
      compare_data("pad_readback", chip_pkg::data_t'(pad_model[s]), rdata);
      compare_flag("pad_readback_err", 1'b0, slverr);
    end
  endtask

  task automatic test_pad_inputs();
    chip_pkg::pin_vec_t pins;
    chip_pkg::addr_t    ofs;
    chip_pkg::data_t    rdata;
    logic [31:0]        r;
    logic               slverr;
    int                 cycles;
    for (int i = 0; i < ITERS; i++) begin
      @(posedge clk_aon);
      #DRIVE_DLY;
      pins     = next_random();
      gpio_p2d = pins;
      repeat (3) @(posedge clk_aon);
      apb_transfer(chip_pkg::PAD_BASE + chip_pkg::PAD_IN_OFS, 1'b0, '0, '0,
                   rdata, slverr, cycles);
      compare_data("pad_input", chip_pkg::data_t'(gather_pins(pins)), rdata);
      compare_flag("pad_input_err", 1'b0, slverr);
    end
    apb_transfer(chip_pkg::PAD_BASE + chip_pkg::PAD_IN_OFS, 1'b1, next_random(), '1,
                 rdata, slverr, cycles);
    compare_flag("pad_input_write_err", 1'b1, slverr);
    // Offsets 0x14 to 0x3f are unlisted and must not touch the registers
    for (int i = 0; i < 6; i++) begin
      r   = next_random();
      ofs = 32'h14 + (r % 11) * 4 + ((r >> 8) % 4);
      apb_transfer(chip_pkg::PAD_BASE + ofs, r[31], next_random(), '1, rdata, slverr, cycles);
      compare_flag("pad_bad_offset_err", 1'b1, slverr);
      @(negedge clk_aon);
      compare_pins("pad_bad_offset_gpio", expected_gpio(), gpio_pins);
    end
  endtask

  //////////////////////
  // Sequence
  //////////////////////
  initial begin
    rst_i       = 1'b1;
    apb_req     = '0;
    gpio_p2d    = '0;
    rng_state   = SEED;
    error_count = 0;
    for (int s = 0; s < 4; s++) pad_model[s] = '0;
    repeat (5) @(posedge clk_aon);
    #DRIVE_DLY;
    rst_i = 1'b0;
    test_power_on();
    test_ram();
    test_decode_error();
    test_pad_outputs();
    test_pad_inputs();
    error_count += chip_ctn_top_inst.ctn_decoder_inst.chip_ctn_assertions_inst.fail_count;
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- project.f
common/chip_pkg.sv
design/por_sequencer.sv
ctn/ctn_decoder.sv
ctn/ctn_sram.sv
padring/pad_regs.sv
padring/pad_map.sv
design/chip_ctn_top.sv
sim/chip_ctn_assertions.sv
sim/chip_ctn_tb.sv
